// ==== bench/frontEndTb.sv ====
`timescale 1ns/1ps

module frontEndTb;
    import isaPkg::*;
    import pipePkg::*;

    localparam int          RESET_CYCLES = 4;
    localparam int          WAIT_LIMIT   = 10;          // Longest legal gap is 2
    localparam int          MEM_WORDS    = 1024;
    localparam int          RAND_LEN     = 200;
    localparam logic [31:0] SEED         = 32'h30fd4787;
    localparam logic [5:0]  FN_ADD       = 6'h20;
    localparam logic [5:0]  FN_SUB       = 6'h22;

    logic        clk;
    logic        rst;
    logic [31:0] imemData;
    logic [31:0] imemAddr;
    issueOp_t    issueOp;

    logic [31:0] imem [0:MEM_WORDS-1];                  // Instruction memory model
    logic [31:0] prog [$];                              // Program under test
    issueOp_t    expOps [$];                            // Expected issue order
    int          expGaps [$];                           // Invalid cycles before each issue
    logic [31:0] lcgState;

    logic [5:0] loadOps  [5] = '{OP_LW, OP_LB, OP_LH, OP_LBU, OP_LHU};
    logic [5:0] storeOps [3] = '{OP_SW, OP_SB, OP_SH};
    logic [5:0] aluOps   [8] = '{OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI,
                                 OP_XORI, OP_SLTI, OP_SLTIU, OP_LUI};
    logic [5:0] functs   [4] = '{FN_ADD, FN_SUB, 6'h24, 6'h25};

    pipeFrontEnd dut_i (
        .clk      (clk),
        .rst      (rst),
        .imemData (imemData),
        .imemAddr (imemAddr),
        .issueOp  (issueOp)
    );

    assign imemData = imem[imemAddr[11:2]];             // Combinational read

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------
    // Failure reporting and checks
    // ------------------------------
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareField(input string name, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
        if (gotVal !== expVal) begin
            abortRun($sformatf("ERR t=%0t %s expected 0x%0h actual 0x%0h",
                               $time, name, expVal, gotVal));
        end
    endtask

    task automatic checkIssue(input issueOp_t expOp, input issueOp_t gotOp);
        compareField("issueOp.valid", expOp.valid, gotOp.valid);
        compareField("issueOp.pc", expOp.pc, gotOp.pc);
        compareField("issueOp.opcode", expOp.opcode, gotOp.opcode);
        compareField("issueOp.funct", expOp.funct, gotOp.funct);
        compareField("issueOp.rs", expOp.rs, gotOp.rs);
        compareField("issueOp.rt", expOp.rt, gotOp.rt);
        compareField("issueOp.dstReg", expOp.dstReg, gotOp.dstReg);
        compareField("issueOp.imm", expOp.imm, gotOp.imm);
        compareField("issueOp.memRead", expOp.memRead, gotOp.memRead);
        compareField("issueOp.memWrite", expOp.memWrite, gotOp.memWrite);
        compareField("issueOp.regWrite", expOp.regWrite, gotOp.regWrite);
        compareField("issueOp.isJump", expOp.isJump, gotOp.isJump);
        compareField("issueOp.usesRs", expOp.usesRs, gotOp.usesRs);
        compareField("issueOp.usesRt", expOp.usesRt, gotOp.usesRt);
    endtask

    task automatic checkBubbles(input int expGap, input int gotGap, input int entry);
        if (gotGap != expGap) begin
            abortRun($sformatf("ERR t=%0t issueOp.valid gap before %0d expected %0d actual %0d",
                               $time, entry, expGap, gotGap));
        end
    endtask

    task automatic checkValid(input logic expBit, input logic gotBit, input string name);
        compareField(name, expBit, gotBit);
    endtask

    task automatic checkAddr(input logic [31:0] expAddr, input logic [31:0] gotAddr);
        compareField("imemAddr", expAddr, gotAddr);
    endtask

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int randBelow(input int n);
        return int'(nextRand() >> 16) % n;              // Upper bits have the longer period
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [5:0] funct);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] opc, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encJ(input logic [5:0] opc, input logic [25:0] idx);
        return {opc, idx};                              // idx is the target word address
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic issueOp_t refDecode(input logic [31:0] pc, input logic [31:0] word);
        issueOp_t op;
        op        = '0;
        op.valid  = 1'b1;
        op.pc     = pc;
        op.opcode = word[31:26];
        op.funct  = word[5:0];
        op.rs     = word[25:21];
        op.rt     = word[20:16];
        op.imm    = word[15:0];
        op.dstReg = word[20:16];                        // rt unless class says otherwise
        case (word[31:26])
            OP_RTYPE: begin
                op.usesRs   = 1'b1;
                op.usesRt   = 1'b1;
                op.regWrite = 1'b1;
                op.dstReg   = word[15:11];
            end
            OP_LW, OP_LB, OP_LH, OP_LBU, OP_LHU: begin
                op.memRead  = 1'b1;
                op.regWrite = 1'b1;
                op.usesRs   = 1'b1;
            end
            OP_SW, OP_SB, OP_SH: begin
                op.memWrite = 1'b1;
                op.usesRs   = 1'b1;
                op.usesRt   = 1'b1;                     // Store data
            end
            OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU: begin
                op.usesRs   = 1'b1;
                op.regWrite = 1'b1;
            end
            OP_LUI:  op.regWrite = 1'b1;
            OP_J:    op.isJump = 1'b1;
            OP_JAL: begin
                op.isJump   = 1'b1;
                op.regWrite = 1'b1;
                op.dstReg   = RA_REG;
            end
            default: ;                                  // Unknown opcode decodes as no-op
        endcase
        return op;
    endfunction

    function automatic logic stallsOn(input issueOp_t prev, input issueOp_t cur);
        return prev.valid && prev.memRead && (prev.dstReg != 5'd0)
            && ((cur.usesRs && cur.rs == prev.dstReg) || (cur.usesRt && cur.rt == prev.dstReg));
    endfunction

    task automatic buildExpected();
        issueOp_t    op;
        issueOp_t    prev;
        logic [31:0] pcPlus4;
        int          idx;
        int          gap;
        expOps.delete();
        expGaps.delete();
        prev = '0;
        idx  = 0;
        while (idx < prog.size()) begin
            op = refDecode(32'(idx * 4), prog[idx]);
            if (expOps.size() == 0) gap = 2;            // Fill of IF/ID and ID/EX
            else if (prev.isJump || stallsOn(prev, op)) gap = 1;
            else gap = 0;
            expOps.push_back(op);
            expGaps.push_back(gap);
            prev    = op;
            pcPlus4 = op.pc + 32'd4;
            if (op.isJump) idx = int'({pcPlus4[31:28], prog[idx][25:0], 2'b00} >> 2);
            else idx++;
        end
    endtask

    function automatic int modelBubbles();
        int total;
        total = 0;
        for (int i = 1; i < expGaps.size(); i++) total += expGaps[i];
        return total;
    endfunction

    // ------------------------------
    // Run control
    // ------------------------------
    task automatic fillMemory();
        for (int a = 0; a < MEM_WORDS; a++) imem[a] = {6'h3f, 26'(a)};  // Unknown opcode
    endtask

    task automatic loadMemory();
        fillMemory();
        for (int i = 0; i < prog.size(); i++) imem[i] = prog[i];
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1 rst = 1'b1;
        loadMemory();                                   // Swapped while held in reset
        @(posedge clk);                                 // First reset edge
        @(negedge clk);
        checkAddr(RESET_PC, imemAddr);
        checkValid(1'b0, issueOp.valid, "issueOp.valid");
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic runProgram(input int count);
        int gap;
        for (int i = 0; i < count; i++) begin
            gap = 0;
            @(negedge clk);                             // Outputs settled mid-cycle
            while (!issueOp.valid) begin
                gap++;
                if (gap > WAIT_LIMIT) begin
                    abortRun($sformatf("Timeout: issue %0d never appeared after %0d cycles",
                                       i, gap));
                end
                @(negedge clk);
            end
            checkBubbles(expGaps[i], gap, i);
            checkIssue(expOps[i], issueOp);
        end
    endtask

    task automatic runTest(input string name, input int bubbles);
        buildExpected();
        if (bubbles >= 0 && modelBubbles() != bubbles) begin
            abortRun($sformatf("Program for %s does not exercise %0d bubbles", name, bubbles));
        end
        applyReset();
        runProgram(expOps.size());
        $display("%s: %0d issues checked", name, expOps.size());
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic buildStraight();
        prog = {encI(OP_ADDI, 0, 1, 16'd5), encI(OP_ORI, 3, 2, 16'h1234),
                encR(1, 2, 4, FN_ADD), encI(OP_LUI, 0, 5, 16'habcd),
                encI(OP_XORI, 4, 6, 16'h00ff), encI(OP_SLTI, 6, 7, 16'hffff),
                encR(7, 5, 8, FN_SUB), encI(OP_ANDI, 8, 9, 16'h0f0f),
                encI(OP_SLTIU, 9, 10, 16'd3), encI(OP_ADDIU, 10, 11, 16'd2)};
    endtask

    task automatic straightLine();
        buildStraight();
        runTest("straight-line", 0);
    endtask

    task automatic loadUseStall();
        prog = {encI(OP_LW, 1, 3, 16'd0), encR(3, 2, 4, FN_ADD),      // rs hit
                encI(OP_LW, 1, 5, 16'd4), encR(2, 5, 6, FN_SUB),      // rt hit
                encI(OP_LW, 1, 7, 16'd8), encI(OP_ADDI, 0, 8, 16'd1),
                encR(7, 7, 9, FN_ADD), encI(OP_ORI, 9, 10, 16'd3)};   // Two slots later
        runTest("load-use", 2);
    endtask

    task automatic noFalseStall();
        prog = {encI(OP_LW, 1, 0, 16'd0), encR(0, 0, 2, FN_ADD),      // Load into r0
                encI(OP_LW, 1, 3, 16'd4), encI(OP_LUI, 3, 4, 16'h1234),
                encI(OP_LW, 1, 5, 16'd8), encI(OP_ADDI, 1, 5, 16'd7), // rt only written
                encI(OP_LW, 1, 7, 16'd12), encI(OP_SW, 1, 7, 16'd16), // Store data stalls
                encI(OP_ADDI, 9, 9, 16'd1)};
        runTest("no false stall", 1);
    endtask

    task automatic jumpRedirect();
        prog = {encI(OP_ADDI, 0, 1, 16'd1), encI(OP_LW, 1, 3, 16'd0),
                encJ(OP_J, 26'd5), encI(OP_ADDI, 0, 2, 16'd9),
                encI(OP_ADDI, 0, 2, 16'd8), encI(OP_ORI, 3, 4, 16'd1),
                encJ(OP_JAL, 26'd9), encI(OP_ADDI, 0, 6, 16'd7),
                encI(OP_ADDI, 0, 6, 16'd6), encR(31, 4, 5, FN_ADD),
                encI(OP_ADDI, 5, 6, 16'd2)};
        runTest("jumps", 2);
    endtask

    task automatic randomPrograms();
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        for (int pass = 0; pass < 2; pass++) begin
            prog.delete();
            for (int i = 0; i < RAND_LEN; i++) begin
                kind = randBelow(8);
                rs   = 5'(randBelow(8));                // Small set for frequent collisions
                rt   = 5'(randBelow(8));
                rd   = 5'(randBelow(8));
                imm  = 16'(nextRand());
                case (kind)
                    0, 1:    prog.push_back(encI(loadOps[randBelow(5)], rs, rt, imm));
                    2:       prog.push_back(encI(storeOps[randBelow(3)], rs, rt, imm));
                    3, 4:    prog.push_back(encR(rs, rt, rd, functs[randBelow(4)]));
                    5, 6:    prog.push_back(encI(aluOps[randBelow(8)], rs, rt, imm));
                    default: prog.push_back(encJ(randBelow(2) == 0 ? OP_J : OP_JAL,
                                                 26'(i + 2 + randBelow(5))));  // Forward only
                endcase
            end
            runTest($sformatf("random %0d", pass), -1);
        end
    endtask

    task automatic resetMidRun();
        buildStraight();
        runTest("straight-line before reset", 0);
        @(posedge clk);
        #1 rst = 1'b1;
        @(posedge clk);                                 // First reset edge
        for (int k = 1; k < RESET_CYCLES; k++) begin
            @(negedge clk);
            checkValid(1'b0, issueOp.valid, "issueOp.valid");
            checkAddr(RESET_PC, imemAddr);
            @(posedge clk);
        end
        #1 rst = 1'b0;
        runProgram(expOps.size());                      // Restart from PC 0
        $display("mid-run reset: %0d issues checked", expOps.size());
    endtask

    initial begin
        rst      = 1'b1;
        lcgState = SEED;
        fillMemory();
        straightLine();
        loadUseStall();
        noFalseStall();
        jumpRedirect();
        randomPrograms();
        resetMidRun();
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== common/isaPkg.sv ====
package isaPkg;

    // ------------------------------
    // Instruction field widths
    // ------------------------------
    localparam int OPC_W   = 6;                      // Primary opcode
    localparam int REG_W   = 5;                      // Register index
    localparam int SHAMT_W = 5;                      // Shift amount
    localparam int FUNCT_W = 6;                      // R-type function code
    localparam int IMM_W   = 16;                     // I-type immediate
    localparam int JIDX_W  = 26;                     // J-type target index

    localparam logic [REG_W-1:0] RA_REG = 5'd31;     // Link register for JAL

    // ------------------------------
    // Opcodes
    // ------------------------------
    localparam logic [OPC_W-1:0] OP_RTYPE = 6'b000000;  // Decoded further by funct
    localparam logic [OPC_W-1:0] OP_J     = 6'b000010;
    localparam logic [OPC_W-1:0] OP_JAL   = 6'b000011;
    localparam logic [OPC_W-1:0] OP_LW    = 6'b100011;  // Loads
    localparam logic [OPC_W-1:0] OP_LB    = 6'b100000;
    localparam logic [OPC_W-1:0] OP_LH    = 6'b100001;
    localparam logic [OPC_W-1:0] OP_LBU   = 6'b100100;
    localparam logic [OPC_W-1:0] OP_LHU   = 6'b100101;
    localparam logic [OPC_W-1:0] OP_SW    = 6'b101011;  // Stores
    localparam logic [OPC_W-1:0] OP_SB    = 6'b101000;
    localparam logic [OPC_W-1:0] OP_SH    = 6'b101001;
    localparam logic [OPC_W-1:0] OP_ADDI  = 6'b001000;  // Immediate ALU
    localparam logic [OPC_W-1:0] OP_ADDIU = 6'b001001;
    localparam logic [OPC_W-1:0] OP_ANDI  = 6'b001100;
    localparam logic [OPC_W-1:0] OP_ORI   = 6'b001101;
    localparam logic [OPC_W-1:0] OP_XORI  = 6'b001110;
    localparam logic [OPC_W-1:0] OP_SLTI  = 6'b001010;
    localparam logic [OPC_W-1:0] OP_SLTIU = 6'b001011;
    localparam logic [OPC_W-1:0] OP_LUI   = 6'b001111;  // No rs read

    // Which field names the written register
    typedef enum logic [1:0] {
        DST_RT,                                      // I-type and loads
        DST_RD,                                      // R-type
        DST_RA                                       // JAL link
    } dstSel_t;

    // Raw instruction word, R-type layout
    typedef struct packed {
        logic [OPC_W-1:0]   opcode;
        logic [REG_W-1:0]   rs;
        logic [REG_W-1:0]   rt;
        logic [REG_W-1:0]   rd;
        logic [SHAMT_W-1:0] shamt;
        logic [FUNCT_W-1:0] funct;
    } instrFields_t;

    // Decoded operation handed from ID to EX
    typedef struct packed {
        logic               valid;                   // Low for bubbles
        logic [31:0]        pc;
        logic [OPC_W-1:0]   opcode;
        logic [FUNCT_W-1:0] funct;
        logic [REG_W-1:0]   rs;
        logic [REG_W-1:0]   rt;
        logic [REG_W-1:0]   dstReg;                  // Resolved destination
        logic [IMM_W-1:0]   imm;
        logic               memRead;
        logic               memWrite;
        logic               regWrite;
        logic               isJump;                  // J or JAL
        logic               usesRs;                  // rs is a real source
        logic               usesRt;                  // rt is a real source
    } issueOp_t;

endpackage

// ==== common/pipePkg.sv ====
package pipePkg;

    // ------------------------------
    // Fetch side
    // ------------------------------
    localparam logic [31:0] RESET_PC = 32'h0000_0000;  // First fetch address

    // Word leaving fetch toward IF/ID
    typedef struct packed {
        logic        valid;                          // Low after flush or reset
        logic [31:0] pc;                             // Address of instr
        logic [31:0] instr;                          // Raw instruction word
    } fetchPkt_t;

    // ------------------------------
    // Hazard control
    // ------------------------------

    // Levels from the hazard unit, all active high
    typedef struct packed {
        logic pcWrite;                               // PC may advance
        logic ifIdWrite;                             // IF/ID may load
        logic ifIdFlush;                             // Kill the IF/ID entry
        logic idExBubble;                            // Insert NOP into ID/EX
    } hazardCtrl_t;

    // Normal flow, no hazard
    localparam hazardCtrl_t CTRL_RUN = '{
        pcWrite:    1'b1,
        ifIdWrite:  1'b1,
        ifIdFlush:  1'b0,
        idExBubble: 1'b0
    };

    // Load-use hold with one bubble
    localparam hazardCtrl_t CTRL_STALL = '{
        pcWrite:    1'b0,
        ifIdWrite:  1'b0,
        ifIdFlush:  1'b0,
        idExBubble: 1'b1
    };

endpackage

// ==== decode/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
    input  isaPkg::issueOp_t     idOp,          // Decoded op in ID
    input  isaPkg::issueOp_t     exOp,          // ID/EX payload
    output pipePkg::hazardCtrl_t ctrl,
    output logic                 redirect       // Select jump target in fetch
);
    import isaPkg::*;
    import pipePkg::*;

    logic [REG_W-1:0] ldDst;                    // Load destination in EX
    logic             ldPending;                // Live load writing a real reg
    logic             rsHit;
    logic             rtHit;
    logic             loadUse;
    logic             jumpHit;

    // ------------------------------
    // Load-use detection
    // ------------------------------
    assign ldDst     = exOp.dstReg;
    assign ldPending = exOp.valid && exOp.memRead && (ldDst != '0);  // r0 never stalls

    // Only sources the consumer actually reads
    assign rsHit   = idOp.usesRs && (idOp.rs == ldDst);
    assign rtHit   = idOp.usesRt && (idOp.rt == ldDst);
    assign loadUse = ldPending && idOp.valid && (rsHit || rtHit);

    // ------------------------------
    // Jump detection
    // ------------------------------
    assign jumpHit  = !loadUse && idOp.valid && idOp.isJump;  // Stall wins
    assign redirect = jumpHit;

    // ------------------------------
    // Control levels
    // ------------------------------
    always_comb begin
        ctrl = CTRL_RUN;                        // Default, everything flows
        if (loadUse) begin
            ctrl = CTRL_STALL;                  // Hold PC and IF/ID, bubble EX
        end else if (jumpHit) begin
            ctrl.pcWrite    = 1'b1;             // Load target
            ctrl.ifIdFlush  = 1'b1;             // Drop sequential successor
            ctrl.idExBubble = 1'b0;             // Jump itself issues
        end
    end

endmodule

// ==== decode/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  pipePkg::fetchPkt_t fetchPkt,        // IF/ID entry
    output isaPkg::issueOp_t   op,
    output logic [31:0]        jumpTarget       // Only meaningful for J/JAL
);
    import isaPkg::*;

    instrFields_t            fields;            // Word split into fields
    dstSel_t                 dstSel;            // Which field is written
    logic [31:0]             pcPlus4;
    logic [JIDX_W-1:0]       jumpIdx;

    assign fields  = instrFields_t'(fetchPkt.instr);
    assign pcPlus4 = fetchPkt.pc + 32'd4;
    assign jumpIdx = fetchPkt.instr[JIDX_W-1:0];

    // Region of PC+4, then index, then word alignment
    assign jumpTarget = {pcPlus4[31:28], jumpIdx, 2'b00};

    // ------------------------------
    // Opcode classes
    // ------------------------------
    always_comb begin
        op          = '0;                       // Unknown opcode is a NOP
        dstSel      = DST_RT;
        op.valid    = fetchPkt.valid;
        op.pc       = fetchPkt.pc;
        op.opcode   = fields.opcode;
        op.funct    = fields.funct;
        op.rs       = fields.rs;
        op.rt       = fields.rt;
        op.imm      = fetchPkt.instr[IMM_W-1:0];

        case (fields.opcode)
            OP_RTYPE: begin
                op.usesRs   = 1'b1;
                op.usesRt   = 1'b1;
                op.regWrite = 1'b1;
                dstSel      = DST_RD;
            end
            OP_LW, OP_LB, OP_LH, OP_LBU, OP_LHU: begin
                op.memRead  = 1'b1;             // Base in rs, result in rt
                op.regWrite = 1'b1;
                op.usesRs   = 1'b1;
                dstSel      = DST_RT;
            end
            OP_SW, OP_SB, OP_SH: begin
                op.memWrite = 1'b1;
                op.usesRs   = 1'b1;             // Address base
                op.usesRt   = 1'b1;             // Store data
            end
            OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI,
            OP_XORI, OP_SLTI, OP_SLTIU: begin
                op.usesRs   = 1'b1;
                op.regWrite = 1'b1;
                dstSel      = DST_RT;
            end
            OP_LUI: begin
                op.regWrite = 1'b1;             // Immediate only, rs unused
                dstSel      = DST_RT;
            end
            OP_J: begin
                op.isJump   = 1'b1;
            end
            OP_JAL: begin
                op.isJump   = 1'b1;
                op.regWrite = 1'b1;
                dstSel      = DST_RA;
            end
            default: begin
                op.regWrite = 1'b0;             // NOP, no sources
            end
        endcase

        // Resolve destination register
        case (dstSel)
            DST_RD:  op.dstReg = fields.rd;
            DST_RA:  op.dstReg = RA_REG;
            default: op.dstReg = fields.rt;
        endcase

        if (!fetchPkt.valid) begin
            op = '0;                            // Flushed slot, clean bubble
        end
    end

endmodule

// ==== filelist.f ====
common/isaPkg.sv
common/pipePkg.sv
rtl/fetchUnit.sv
rtl/stageReg.sv
decode/instrDecoder.sv
decode/hazardUnit.sv
rtl/pipeFrontEnd.sv
bench/frontEndTb.sv

// ==== rtl/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit (
    input  logic                 clk,
    input  logic                 rst,
    input  pipePkg::hazardCtrl_t ctrl,          // Only pcWrite matters here
    input  logic                 redirect,      // Take jumpTarget
    input  logic [31:0]          jumpTarget,
    input  logic [31:0]          imemData,      // Word at imemAddr, same cycle
    output logic [31:0]          imemAddr,
    output pipePkg::fetchPkt_t   fetchPkt
);
    import pipePkg::*;

    logic [31:0] pc;                            // Current fetch address
    logic [31:0] pcPlus4;                       // Sequential successor
    logic [31:0] pcNext;                        // Selected next address

    // ------------------------------
    // Next PC
    // ------------------------------
    assign pcPlus4 = pc + 32'd4;
    assign pcNext  = redirect ? jumpTarget : pcPlus4;  // Hazard unit already qualified

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (ctrl.pcWrite) begin        // Held during load-use stall
            pc <= pcNext;
        end
    end

    // ------------------------------
    // Instruction memory side
    // ------------------------------
    assign imemAddr = pc;                       // Memory answers combinationally

    // Every fetched word is valid, flushes happen in IF/ID
    always_comb begin
        fetchPkt.valid = 1'b1;
        fetchPkt.pc    = pc;
        fetchPkt.instr = imemData;
    end

endmodule

// ==== rtl/pipeFrontEnd.sv ====
`timescale 1ns/1ps

module pipeFrontEnd (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      imemData,          // Instruction memory read data
    output logic [31:0]      imemAddr,          // Current PC
    output isaPkg::issueOp_t issueOp            // Toward execute
);
    import isaPkg::*;
    import pipePkg::*;

    // ------------------------------
    // Internal nets
    // ------------------------------
    hazardCtrl_t ctrl;                          // From hazard unit
    logic        redirect;                      // Jump taken this cycle
    logic [31:0] jumpTarget;                    // From decoder
    fetchPkt_t   fetchPkt;                      // Fetch to IF/ID
    fetchPkt_t   ifIdPkt;                       // IF/ID to decode
    issueOp_t    idOp;                          // Decoded op in ID

    // ------------------------------
    // IF stage
    // ------------------------------
    fetchUnit uFetch (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .redirect   (redirect),
        .jumpTarget (jumpTarget),
        .imemData   (imemData),
        .imemAddr   (imemAddr),
        .fetchPkt   (fetchPkt)
    );

    // IF/ID register, held on stall, flushed on jump
    stageReg #(
        .payload_t (fetchPkt_t)
    ) ifIdReg (
        .clk   (clk),
        .rst   (rst),
        .hold  (!ctrl.ifIdWrite),
        .clear (ctrl.ifIdFlush),
        .d     (fetchPkt),
        .q     (ifIdPkt)
    );

    // ------------------------------
    // ID stage
    // ------------------------------
    instrDecoder uDecoder (
        .fetchPkt   (ifIdPkt),
        .op         (idOp),
        .jumpTarget (jumpTarget)
    );

    // Compares ID against the op sitting in ID/EX
    hazardUnit uHazard (
        .idOp     (idOp),
        .exOp     (issueOp),
        .ctrl     (ctrl),
        .redirect (redirect)
    );

    // ID/EX register, never held, bubbled on load-use
    stageReg #(
        .payload_t (issueOp_t)
    ) idExReg (
        .clk   (clk),
        .rst   (rst),
        .hold  (1'b0),
        .clear (ctrl.idExBubble),
        .d     (idOp),
        .q     (issueOp)
    );

endmodule

// ==== rtl/stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
    parameter type payload_t = logic [31:0]     // Packet or decoded op
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,                      // Keep current entry
    input  logic     clear,                     // Load an empty entry
    input  payload_t d,
    output payload_t q
);

    // ------------------------------
    // Stage storage
    // ------------------------------

    // All-zero payload means valid low, i.e. a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= payload_t'('0);
        end else if (clear) begin               // Wins over hold
            q <= payload_t'('0);
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule
